// ==== common/mem_bus_pkg.sv ====
/* Shared layout of the packed memory bus. Forward word from the top holds
   write data, strobes, valid and address. Return word has ready above the read data */

package mem_bus_pkg;

    // --------------------
    // Field widths
    // --------------------
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ADDR_W = 32;

    // Whole bus words
    localparam int FWD_W = DATA_W + STRB_W + 1 + ADDR_W;
    localparam int RET_W = 1 + DATA_W;

    // --------------------
    // Forward word fields
    // --------------------
    // Address sits at the bottom
    localparam int FWD_ADDR_LSB  = 0;
    localparam int FWD_VALID_BIT = FWD_ADDR_LSB + ADDR_W;
    localparam int FWD_WSTRB_LSB = FWD_VALID_BIT + 1;
    // Write data takes the top 32 bits
    localparam int FWD_WDATA_LSB = FWD_WSTRB_LSB + STRB_W;

    // Return word, read data in bits 31 to 0
    localparam int RET_READY_BIT = DATA_W;

    // --------------------
    // Address decode
    // --------------------
    // Select field is the top address byte
    localparam int SEL_W   = 8;
    localparam int SEL_LSB = ADDR_W - SEL_W;

    // Default target selects
    localparam logic [SEL_W-1:0] DEF_SRAM_BASE = 8'h00;
    localparam logic [SEL_W-1:0] DEF_BRAM_BASE = 8'h01;

endpackage

// ==== sram/sram_byte_ctrl.sv ====
/* Byte-serial controller for an async 8-bit SRAM, one clock per byte.
   Write ready after 4 edges, read ready after 5. SRAM access time must fit one clock */
`timescale 1ns/1ps

module sram_byte_ctrl #(
    parameter logic [mem_bus_pkg::SEL_W-1:0] BASE = mem_bus_pkg::DEF_SRAM_BASE
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [mem_bus_pkg::FWD_W-1:0] fwd,
    output logic [mem_bus_pkg::RET_W-1:0] ret,
    inout  logic [7:0]                    ram_data_z,
    output logic [23:0]                   ram_address,
    output logic                          ram_nwe,
    output logic                          ram_nce,
    output logic                          ram_noe
);

    // Decoded forward word
    logic [mem_bus_pkg::DATA_W-1:0] wdata;
    logic [mem_bus_pkg::STRB_W-1:0] wstrb;
    logic                           valid;
    logic [mem_bus_pkg::ADDR_W-1:0] addr;

    logic        selected;
    logic        ready;
    logic        is_last;
    logic [2:0]  cnt;
    logic [1:0]  byte_sel;
    logic [1:0]  rd_slot;
    logic [7:0]  w_reg;
    logic [7:0]  r_reg;
    logic [23:0] rdata;

    // --------------------
    // Bus decode
    // --------------------
    assign wdata = fwd[mem_bus_pkg::FWD_WDATA_LSB +: mem_bus_pkg::DATA_W];
    assign wstrb = fwd[mem_bus_pkg::FWD_WSTRB_LSB +: mem_bus_pkg::STRB_W];
    assign valid = fwd[mem_bus_pkg::FWD_VALID_BIT];
    assign addr  = fwd[mem_bus_pkg::FWD_ADDR_LSB +: mem_bus_pkg::ADDR_W];

    assign selected = valid && (addr[mem_bus_pkg::SEL_LSB +: mem_bus_pkg::SEL_W] == BASE);

    // Byte lane of the current step
    assign byte_sel = cnt[1:0];
    // Read bytes land two steps late, count 2..4 maps to slot 0..2
    assign rd_slot  = cnt[1:0] - 2'd2;

    // Reads need the extra edge for the input register
    assign is_last = cnt >= ((|wstrb) ? 3'd3 : 3'd4);

    // --------------------
    // SRAM pins
    // --------------------
    // Chip and output enable stay on, write enable alone steers direction
    assign ram_nce = 1'b0;
    assign ram_noe = 1'b0;

    // Drive only during a write pulse
    assign ram_data_z = ram_nwe ? 8'hzz : w_reg;

    // Step counter, write strobe and ready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt     <= 3'd0;
            ready   <= 1'b0;
            ram_nwe <= 1'b1;
        end else begin
            ready   <= 1'b0;
            ram_nwe <= 1'b1;
            if (selected && !ready) begin
                // Skip the write pulse for unstrobed bytes
                ram_nwe <= !wstrb[byte_sel];
                ready   <= is_last;
                cnt     <= cnt + 3'd1;
            end else begin
                cnt <= 3'd0;
            end
        end
    end

    // Data path registers, close to the pads
    always_ff @(posedge clk) begin
        // Pins sampled every cycle, writes just ignore it
        r_reg       <= ram_data_z;
        w_reg       <= wdata[8*byte_sel +: 8];
        ram_address <= addr[23:0] + 24'(cnt);
        if (selected && !ready) begin
            if (cnt >= 3'd2) begin
                rdata[8*rd_slot +: 8] <= r_reg;
            end
        end else begin
            rdata <= 24'h0;
        end
    end

    // Byte 3 comes straight from the input register in the ready cycle
    assign ret[mem_bus_pkg::RET_READY_BIT] = ready;
    assign ret[mem_bus_pkg::RET_READY_BIT-1:0] = ready ? {r_reg, rdata} : '0;

    // --------------------
    // Checks
    // --------------------
    // Master holds strobes for the whole access
    a_strb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        selected && !ready |=> !selected || $stable(wstrb));

    // Pins driven only while a write to this target is still held
    a_drive_in_write: assert property (@(posedge clk) disable iff (!arst_n)
        !ram_nwe |-> selected && (|wstrb));

endmodule

// ==== hdl/bram_port.sv ====
/* On-chip word RAM target with byte strobes, ready one edge after a request.
   Addresses beyond BRAM_WORDS wrap, BRAM_WORDS must be a power of two */
`timescale 1ns/1ps

module bram_port #(
    parameter logic [mem_bus_pkg::SEL_W-1:0] BASE       = mem_bus_pkg::DEF_BRAM_BASE,
    parameter int                            BRAM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [mem_bus_pkg::FWD_W-1:0] fwd,
    output logic [mem_bus_pkg::RET_W-1:0] ret
);

    localparam int IDX_W = $clog2(BRAM_WORDS);

    logic [mem_bus_pkg::DATA_W-1:0] wdata;
    logic [mem_bus_pkg::STRB_W-1:0] wstrb;
    logic                           valid;
    logic [mem_bus_pkg::ADDR_W-1:0] addr;

    logic                           selected;
    logic                           accept;
    logic                           ready;
    logic [21:0]                    word_addr;
    logic [IDX_W-1:0]               idx;
    logic [mem_bus_pkg::DATA_W-1:0] rdata;
    logic [mem_bus_pkg::DATA_W-1:0] mem [BRAM_WORDS];

    assign wdata = fwd[mem_bus_pkg::FWD_WDATA_LSB +: mem_bus_pkg::DATA_W];
    assign wstrb = fwd[mem_bus_pkg::FWD_WSTRB_LSB +: mem_bus_pkg::STRB_W];
    assign valid = fwd[mem_bus_pkg::FWD_VALID_BIT];
    assign addr  = fwd[mem_bus_pkg::FWD_ADDR_LSB +: mem_bus_pkg::ADDR_W];

    assign selected = valid && (addr[mem_bus_pkg::SEL_LSB +: mem_bus_pkg::SEL_W] == BASE);
    // Held request is answered once, the ready cycle blocks a repeat
    assign accept   = selected && !ready;

    // Word address below the select byte
    assign word_addr = addr[23:2];
    assign idx       = word_addr[IDX_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= accept;
        end
    end

    // Read old word, then merge strobed bytes
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[idx];
            for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign ret = ready ? {1'b1, rdata} : '0;

    // Software must stay inside the RAM window
    a_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
        selected |-> word_addr < BRAM_WORDS);

endmodule

// ==== hdl/bus_return_mux.sv ====
/* Merges target returns by OR, each target returns zero when idle.
   Unmapped accesses get ready with zero data and a bus_error pulse one edge later */
`timescale 1ns/1ps

module bus_return_mux #(
    parameter logic [mem_bus_pkg::SEL_W-1:0] SRAM_BASE = mem_bus_pkg::DEF_SRAM_BASE,
    parameter logic [mem_bus_pkg::SEL_W-1:0] BRAM_BASE = mem_bus_pkg::DEF_BRAM_BASE
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [mem_bus_pkg::FWD_W-1:0] fwd,
    input  logic [mem_bus_pkg::RET_W-1:0] sram_ret,
    input  logic [mem_bus_pkg::RET_W-1:0] bram_ret,
    output logic [mem_bus_pkg::RET_W-1:0] ret,
    output logic                          bus_error
);

    logic                          valid;
    logic [mem_bus_pkg::SEL_W-1:0] sel;
    logic                          unmapped;
    logic                          err_q;
    logic [mem_bus_pkg::RET_W-1:0] err_ret;

    // --------------------
    // Stray access detect
    // --------------------
    assign valid = fwd[mem_bus_pkg::FWD_VALID_BIT];
    assign sel   = fwd[mem_bus_pkg::FWD_ADDR_LSB + mem_bus_pkg::SEL_LSB +: mem_bus_pkg::SEL_W];

    assign unmapped = valid && (sel != SRAM_BASE) && (sel != BRAM_BASE);

    // One pulse per request, the held word is not answered twice
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= unmapped && !err_q;
        end
    end

    assign bus_error = err_q;

    // Ready only, read data stays zero
    always_comb begin
        err_ret = '0;
        err_ret[mem_bus_pkg::RET_READY_BIT] = err_q;
    end

    // --------------------
    // Merge
    // --------------------
    assign ret = sram_ret | bram_ret | err_ret;

    // Decode keeps targets exclusive, so OR never mixes two answers
    a_one_ready: assert property (@(posedge clk) disable iff (!arst_n)
        !(sram_ret[mem_bus_pkg::RET_READY_BIT] && bram_ret[mem_bus_pkg::RET_READY_BIT]));

endmodule

// ==== hdl/mem_subsys.sv ====
/* Memory back end, external SRAM and on-chip RAM on one packed bus.
   The return merge is combinational, target latencies show unchanged at the top */
`timescale 1ns/1ps

module mem_subsys #(
    parameter logic [mem_bus_pkg::SEL_W-1:0] SRAM_BASE  = mem_bus_pkg::DEF_SRAM_BASE,
    parameter logic [mem_bus_pkg::SEL_W-1:0] BRAM_BASE  = mem_bus_pkg::DEF_BRAM_BASE,
    parameter int                            BRAM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [mem_bus_pkg::FWD_W-1:0] mem_packed_fwd,
    output logic [mem_bus_pkg::RET_W-1:0] mem_packed_ret,
    inout  logic [7:0]                    ram_data_z,
    output logic [23:0]                   ram_address,
    output logic                          ram_nwe,
    output logic                          ram_nce,
    output logic                          ram_noe,
    output logic                          bus_error
);

    // Per target returns, zero when idle
    logic [mem_bus_pkg::RET_W-1:0] sram_ret;
    logic [mem_bus_pkg::RET_W-1:0] bram_ret;

    // --------------------
    // Targets
    // --------------------
    sram_byte_ctrl #(
        .BASE (SRAM_BASE)
    ) i_sram_byte_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .fwd         (mem_packed_fwd),
        .ret         (sram_ret),
        .ram_data_z  (ram_data_z),
        .ram_address (ram_address),
        .ram_nwe     (ram_nwe),
        .ram_nce     (ram_nce),
        .ram_noe     (ram_noe)
    );

    bram_port #(
        .BASE       (BRAM_BASE),
        .BRAM_WORDS (BRAM_WORDS)
    ) i_bram_port (
        .clk    (clk),
        .arst_n (arst_n),
        .fwd    (mem_packed_fwd),
        .ret    (bram_ret)
    );

    // Merge and unmapped responder
    bus_return_mux #(
        .SRAM_BASE (SRAM_BASE),
        .BRAM_BASE (BRAM_BASE)
    ) i_bus_return_mux (
        .clk       (clk),
        .arst_n    (arst_n),
        .fwd       (mem_packed_fwd),
        .sram_ret  (sram_ret),
        .bram_ret  (bram_ret),
        .ret       (mem_packed_ret),
        .bus_error (bus_error)
    );

endmodule

// ==== testbench/sram_model.sv ====
/* Behavioral async 512K x 8 SRAM without timing, upper address bits ignored.
   A write lands when address, data or nWE moves, with the pair that was stable before */
`timescale 1ns/1ps

module sram_model #(
    parameter int ADDR_BITS = 19
) (
    inout  wire  [7:0]  ram_data_z,
    input  logic [23:0] ram_address,
    input  logic        ram_nce,
    input  logic        ram_noe,
    input  logic        ram_nwe
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [7:0]           mem [DEPTH];
    logic                 wr_open  = 1'b0;
    logic [ADDR_BITS-1:0] wr_addr  = '0;
    logic [7:0]           wr_data  = 8'h00;
    realtime              wr_since = 0.0;

    // Fill mixes every address bit so stale reads stand out
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ {5'b0, i[18:16]};
        end
    end

    // Read drive while not writing
    assign ram_data_z = (!ram_nce && !ram_noe && ram_nwe) ? mem[ram_address[ADDR_BITS-1:0]]
                                                          : 8'hzz;

    // --------------------
    // Write cycle tracking
    // --------------------
    always @(ram_address or ram_data_z or ram_nwe or ram_nce) begin
        // Same time step changes are glitches, only a settled pair is stored
        if (wr_open && ($realtime > wr_since)) begin
            mem[wr_addr] = wr_data;
        end
        wr_open  = !ram_nce && !ram_nwe;
        wr_addr  = ram_address[ADDR_BITS-1:0];
        wr_data  = ram_data_z;
        wr_since = $realtime;
    end

endmodule

// ==== testbench/tb_mem_subsys.sv ====
/* Trace driven testbench for mem_subsys, stops at the first mismatch.
   Trace path is relative to the project root */
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int         DRIVE_DLY   = 1;
    localparam int         READY_LIMIT = 20;
    localparam logic [7:0] SRAM_SEL    = 8'h00;
    localparam logic [7:0] BRAM_SEL    = 8'h01;

    logic                          clk;
    logic                          arst_n;
    logic [mem_bus_pkg::FWD_W-1:0] mem_packed_fwd;
    logic [mem_bus_pkg::RET_W-1:0] mem_packed_ret;
    wire  [7:0]                    ram_data_z;
    logic [23:0]                   ram_address;
    logic                          ram_nwe;
    logic                          ram_nce;
    logic                          ram_noe;
    logic                          bus_error;
    int                            access_no;

    // 4 ns period
    always #2 clk = ~clk;

    mem_subsys #(
        .SRAM_BASE  (SRAM_SEL),
        .BRAM_BASE  (BRAM_SEL),
        .BRAM_WORDS (256)
    ) i_mem_subsys (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_packed_fwd (mem_packed_fwd),
        .mem_packed_ret (mem_packed_ret),
        .ram_data_z     (ram_data_z),
        .ram_address    (ram_address),
        .ram_nwe        (ram_nwe),
        .ram_nce        (ram_nce),
        .ram_noe        (ram_noe),
        .bus_error      (bus_error)
    );

    sram_model i_sram_model (
        .ram_data_z  (ram_data_z),
        .ram_address (ram_address),
        .ram_nce     (ram_nce),
        .ram_noe     (ram_noe),
        .ram_nwe     (ram_nwe)
    );

    // --------------------
    // Helpers
    // --------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                                $time, name, expected, actual));
        end
    endtask

    // SRAM write 4 edges, read 5, BRAM and unmapped 1
    function automatic int expected_latency(input logic [7:0] op, input logic [31:0] addr);
        if (addr[31:24] == SRAM_SEL) begin
            return (op == "W") ? 4 : 5;
        end
        return 1;
    endfunction

    function automatic logic [mem_bus_pkg::FWD_W-1:0] pack_request(
        input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] strb);
        logic [mem_bus_pkg::FWD_W-1:0] w;
        w = '0;
        w[mem_bus_pkg::FWD_ADDR_LSB +: 32] = addr;
        w[mem_bus_pkg::FWD_VALID_BIT]      = 1'b1;
        w[mem_bus_pkg::FWD_WSTRB_LSB +: 4] = strb;
        w[mem_bus_pkg::FWD_WDATA_LSB +: 32] = wdata;
        return w;
    endfunction

    // Entered 1 ns after an edge, leaves 1 ns after the edge following ready
    task automatic run_access(input logic [7:0] op, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              input logic [31:0] exp_rdata, input logic exp_err);
        int          edges;
        logic        got_ready;
        logic [23:0] exp_addr;
        edges     = 0;
        got_ready = 1'b0;
        mem_packed_fwd = pack_request(addr, wdata, strb);
        while (!got_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
            got_ready = mem_packed_ret[mem_bus_pkg::RET_READY_BIT];
            // Byte k sits on the SRAM pins after edge k+1
            // nWE pulses low only for strobed write bytes
            if (addr[31:24] == SRAM_SEL && edges <= 4) begin
                exp_addr = addr[23:0] + edges - 1;
                check_value("ram_address", exp_addr, ram_address);
                check_value("ram_nwe", (op == "W" && strb[edges-1]) ? 32'h0 : 32'h1, ram_nwe);
            end
            if (!got_ready) begin
                check_value("bus_error", 32'h0, bus_error);
                if (edges >= READY_LIMIT) begin
                    abort_run($sformatf("Access %0d (%c at %h) got no ready in %0d cycles",
                                        access_no, op, addr, READY_LIMIT));
                end
            end
        end
        check_value("ready_latency", expected_latency(op, addr), edges);
        check_value("bus_error", exp_err, bus_error);
        // Write data returned by the SRAM path is junk
        if (op == "R" || exp_err) begin
            check_value("mem_packed_ret.rdata", exp_rdata, mem_packed_ret[31:0]);
        end
        // Request held through the ready cycle
        @(posedge clk);
        #DRIVE_DLY;
        check_value("mem_packed_ret.ready", 32'h0, mem_packed_ret[mem_bus_pkg::RET_READY_BIT]);
        check_value("bus_error", 32'h0, bus_error);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_rdata;
        logic        exp_err;
        clk            = 1'b0;
        arst_n         = 1'b0;
        mem_packed_fwd = '0;
        access_no      = 0;
        line_no        = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        check_value("mem_packed_ret.ready", 32'h0, mem_packed_ret[mem_bus_pkg::RET_READY_BIT]);
        check_value("ram_nwe", 32'h1, ram_nwe);
        check_value("ram_nce", 32'h0, ram_nce);
        check_value("ram_noe", 32'h0, ram_noe);
        check_value("bus_error", 32'h0, bus_error);
        arst_n = 1'b1;
        fd = $fopen("testbench/mem_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open trace file testbench/mem_trace.txt");
        end
        // Each record starts right after the previous one, no idle cycle
        while (!$feof(fd) && line_no < 1000) begin
            n = $fgets(line, fd);
            line_no++;
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, strb, exp_rdata,
                            exp_err);
                if (n != 6 || (op != "R" && op != "W")) begin
                    abort_run($sformatf("Trace line %0d cannot be parsed", line_no));
                end
                access_no++;
                run_access(op, addr, wdata, strb, exp_rdata, exp_err);
            end
        end
        $fclose(fd);
        // Idle bus stays quiet
        mem_packed_fwd = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        check_value("mem_packed_ret.ready", 32'h0, mem_packed_ret[mem_bus_pkg::RET_READY_BIT]);
        check_value("bus_error", 32'h0, bus_error);
        if (access_no > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("Trace file held no access records");
        end
    end

endmodule

// ==== testbench/mem_trace.txt ====
# op addr wdata strb exp_rdata exp_err
# op is W for write or R for read, other fields hex, exp_rdata checked on reads and errors
W 00000100 11223344 f 00000000 0
R 00000100 00000000 0 11223344 0
W 00000100 aabbccdd 5 00000000 0
R 00000100 00000000 0 11bb33dd 0
W 00000104 cafef00d f 00000000 0
W 00000104 12345678 8 00000000 0
R 00000104 00000000 0 12fef00d 0
W 01000010 deadbeef f 00000000 0
R 01000010 00000000 0 deadbeef 0
W 01000010 00990000 4 00000000 0
R 01000010 00000000 0 de99beef 0
W 00000200 a1a2a3a4 f 00000000 0
W 01000020 b1b2b3b4 f 00000000 0
W 00000010 0f0e0d0c f 00000000 0
R 00000200 00000000 0 a1a2a3a4 0
R 01000020 00000000 0 b1b2b3b4 0
R 01000010 00000000 0 de99beef 0
R 00000010 00000000 0 0f0e0d0c 0
R 02000000 00000000 0 00000000 1
W 7f000040 55555555 f 00000000 1
R ff000104 00000000 0 00000000 1
R 00000104 00000000 0 12fef00d 0

// ==== compile.f ====
common/mem_bus_pkg.sv
sram/sram_byte_ctrl.sv
hdl/bram_port.sv
hdl/bus_return_mux.sv
hdl/mem_subsys.sv
testbench/sram_model.sv
testbench/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - common/mem_bus_pkg.sv
      - sram/sram_byte_ctrl.sv
      - hdl/bram_port.sv
      - hdl/bus_return_mux.sv
      - hdl/mem_subsys.sv
  - target: simulation
    files:
      - testbench/sram_model.sv
      - testbench/tb_mem_subsys.sv
